/* hdl/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// data and address width.
`define XLEN 32

`define REG_ADDR_W 5
`define NUM_REGS 32

// addi x0, x0, 0.
`define NOP_INSTR 32'h0000_0013

`endif

/* hdl/decode_pkg.sv */
package decode_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // lui, result is the immediate.
    } alu_op_t;

    typedef enum logic [2:0] {
        bcu_none,
        bcu_beq,
        bcu_bne,
        bcu_blt,
        bcu_bge,
        bcu_bltu,
        bcu_bgeu
    } bcu_op_t;

    typedef enum logic [3:0] {
        lsu_none,
        lsu_lb,
        lsu_lbu,
        lsu_lh,
        lsu_lhu,
        lsu_lw,
        lsu_sb,
        lsu_sh,
        lsu_sw
    } lsu_op_t;

    // machine cause numbers.
    typedef enum logic [3:0] {
        except_instr_misaligned    = 4'd0,
        except_illegal_instruction = 4'd2,
        except_breakpoint          = 4'd3,
        except_load_misaligned     = 4'd4,
        except_store_misaligned    = 4'd6,
        except_env_call_mach       = 4'd11
    } ecause_t;

endpackage

/* hdl/instr_decoder.sv */
`include "decode_macros.svh"

module instr_decoder
    import decode_pkg::*;
(
    input  logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] imm,
    output logic [`REG_ADDR_W-1:0] waddr, raddr1, raddr2,
    output logic wren, rden1, rden2, lui, auipc, jal, jalr, branch,
    output logic load, store, ecall, ebreak, valid,
    output alu_op_t alu_op,
    output bcu_op_t bcu_op,
    output lsu_op_t lsu_op
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign waddr = instr[11:7];
    assign raddr1 = instr[19:15];
    assign raddr2 = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        imm = '0;
        {wren, rden1, rden2, lui, auipc, jal, jalr, branch, load, store, ecall, ebreak, valid} = '0;
        alu_op = alu_add;
        bcu_op = bcu_none;
        lsu_op = lsu_none;
        case (opcode)
            7'b0110111: begin
                imm = imm_u;
                {lui, wren, valid} = 3'b111;
                alu_op = alu_pass_b;
            end
            7'b0010111: begin
                imm = imm_u;
                {auipc, wren, valid} = 3'b111;
            end
            7'b1101111: begin
                imm = imm_j;
                {jal, wren, valid} = 3'b111;
            end
            7'b1100111: begin
                imm = imm_i;
                {jalr, wren, rden1, valid} = {4{funct3 == 3'b000}};
            end
            7'b1100011: begin
                imm = imm_b;
                case (funct3)
                    3'b000: bcu_op = bcu_beq;
                    3'b001: bcu_op = bcu_bne;
                    3'b100: bcu_op = bcu_blt;
                    3'b101: bcu_op = bcu_bge;
                    3'b110: bcu_op = bcu_bltu;
                    3'b111: bcu_op = bcu_bgeu;
                    default: bcu_op = bcu_none;
                endcase
                {branch, rden1, rden2, valid} = {4{bcu_op != bcu_none}};
            end
            7'b0000011: begin
                imm = imm_i;
                case (funct3)
                    3'b000: lsu_op = lsu_lb;
                    3'b001: lsu_op = lsu_lh;
                    3'b010: lsu_op = lsu_lw;
                    3'b100: lsu_op = lsu_lbu;
                    3'b101: lsu_op = lsu_lhu;
                    default: lsu_op = lsu_none;
                endcase
                {load, wren, rden1, valid} = {4{lsu_op != lsu_none}};
            end
            7'b0100011: begin
                imm = imm_s;
                case (funct3)
                    3'b000: lsu_op = lsu_sb;
                    3'b001: lsu_op = lsu_sh;
                    3'b010: lsu_op = lsu_sw;
                    default: lsu_op = lsu_none;
                endcase
                {store, rden1, rden2, valid} = {4{lsu_op != lsu_none}};
            end
            7'b0010011, 7'b0110011: begin
                imm = imm_i;  // ignored by execute for register ops.
                case (funct3)
                    3'b000: alu_op = (opcode[5] && instr[30]) ? alu_sub : alu_add;
                    3'b001: alu_op = alu_sll;
                    3'b010: alu_op = alu_slt;
                    3'b011: alu_op = alu_sltu;
                    3'b100: alu_op = alu_xor;
                    3'b101: alu_op = instr[30] ? alu_sra : alu_srl;
                    3'b110: alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
                // funct7 only carries bit 30, and only for sub and sra.
                if (!opcode[5] && funct3 != 3'b001 && funct3 != 3'b101) begin
                    valid = 1'b1;
                end else begin
                    valid = (funct7 == 7'b0) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b101 ||
                             (opcode[5] && funct3 == 3'b000)));
                end
                {wren, rden1} = {2{valid}};
                rden2 = valid && opcode[5];
            end
            7'b0001111: valid = 1'b1;  // fence, nothing to order in decode.
            7'b1110011: begin
                ecall = (instr == 32'h0000_0073);
                ebreak = (instr == 32'h0010_0073);
                valid = ecall || ebreak;
            end
            default: valid = 1'b0;
        endcase
    end

endmodule

/* hdl/register_file.sv */
`include "decode_macros.svh"

module register_file (
    input  logic clock,
    input  logic reset,
    input  logic [`REG_ADDR_W-1:0] raddr1, raddr2,
    input  logic rden1, rden2,
    input  logic wb_wren,
    input  logic [`REG_ADDR_W-1:0] wb_waddr,
    input  logic [`XLEN-1:0] wb_wdata,
    output logic [`XLEN-1:0] rdata1, rdata2
);
    logic [`XLEN-1:0] regs [`NUM_REGS];

    // x0 is cleared here and never written afterwards.
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wren && wb_waddr != '0) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

    // same-cycle writeback is picked up by the forwarding unit.
    assign rdata1 = rden1 ? regs[raddr1] : '0;
    assign rdata2 = rden2 ? regs[raddr2] : '0;

endmodule

/* hdl/operand_forward.sv */
`include "decode_macros.svh"

module operand_forward (
    input  logic [`REG_ADDR_W-1:0] raddr1, raddr2,
    input  logic rden1, rden2,
    input  logic [`XLEN-1:0] rdata1, rdata2,
    input  logic ex_wren,
    input  logic [`REG_ADDR_W-1:0] ex_waddr,
    input  logic [`XLEN-1:0] ex_wdata,
    input  logic wb_wren,
    input  logic [`REG_ADDR_W-1:0] wb_waddr,
    input  logic [`XLEN-1:0] wb_wdata,
    output logic [`XLEN-1:0] data1, data2
);
    // execute is newer than writeback, so it is checked first.
    function automatic logic [`XLEN-1:0] select_operand(
        input logic rden,
        input logic [`REG_ADDR_W-1:0] raddr,
        input logic [`XLEN-1:0] rdata
    );
        if (rden && raddr != '0 && ex_wren && ex_waddr == raddr) begin
            return ex_wdata;
        end else if (rden && raddr != '0 && wb_wren && wb_waddr == raddr) begin
            return wb_wdata;
        end
        return rdata;
    endfunction

    always_comb begin
        data1 = select_operand(rden1, raddr1, rdata1);
        data2 = select_operand(rden2, raddr2, rdata2);
    end

endmodule

/* hdl/branch_compare.sv */
`include "decode_macros.svh"

module branch_compare
    import decode_pkg::*;
(
    input  logic [`XLEN-1:0] data1, data2,
    input  bcu_op_t bcu_op,
    output logic taken
);
    logic equal;
    logic less;
    logic less_u;

    assign equal = (data1 == data2);
    assign less = ($signed(data1) < $signed(data2));
    assign less_u = (data1 < data2);

    always_comb begin
        case (bcu_op)
            bcu_beq: taken = equal;
            bcu_bne: taken = !equal;
            bcu_blt: taken = less;
            bcu_bge: taken = !less;
            bcu_bltu: taken = less_u;
            bcu_bgeu: taken = !less_u;
            default: taken = 1'b0;
        endcase
    end

endmodule

/* hdl/address_gen.sv */
`include "decode_macros.svh"

module address_gen
    import decode_pkg::*;
(
    input  logic [`XLEN-1:0] pc, data1, imm,
    input  logic jal, jalr, branch, load, store,
    input  lsu_op_t lsu_op,
    output logic [`XLEN-1:0] address,
    output logic [3:0] byteenable,
    output logic exception,
    output ecause_t ecause
);
    logic [`XLEN-1:0] sum_reg;
    logic [`XLEN-1:0] sum_pc;

    assign sum_reg = data1 + imm;
    assign sum_pc = pc + imm;

    always_comb begin
        if (jalr) begin
            address = {sum_reg[`XLEN-1:1], 1'b0};
        end else if (load || store) begin
            address = sum_reg;
        end else if (jal || branch) begin
            address = sum_pc;
        end else begin
            address = '0;
        end
    end

    always_comb begin
        byteenable = 4'b0000;
        exception = 1'b0;
        ecause = except_instr_misaligned;
        case (lsu_op)
            lsu_lb, lsu_lbu, lsu_sb: byteenable = 4'b0001 << address[1:0];
            lsu_lh, lsu_lhu, lsu_sh: begin
                byteenable = address[1] ? 4'b1100 : 4'b0011;
                exception = address[0];
            end
            lsu_lw, lsu_sw: begin
                byteenable = 4'b1111;
                exception = (address[1:0] != 2'b00);
            end
            default: byteenable = 4'b0000;
        endcase
        if (load) begin
            ecause = except_load_misaligned;
        end else if (store) begin
            ecause = except_store_misaligned;
        end else begin
            exception = (jal || jalr || branch) && (address[1:0] != 2'b00);  // no compressed.
        end
    end

endmodule

/* hdl/decode_stage.sv */
`include "decode_macros.svh"

module decode_stage
    import decode_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic [`XLEN-1:0] pc, instr,
    input  logic ex_busy,
    input  logic clear,
    input  logic ex_wren,
    input  logic [`REG_ADDR_W-1:0] ex_waddr,
    input  logic [`XLEN-1:0] ex_wdata,
    input  logic wb_wren,
    input  logic [`REG_ADDR_W-1:0] wb_waddr,
    input  logic [`XLEN-1:0] wb_wdata,
    output logic stall,
    output logic [`XLEN-1:0] pc_out, npc, imm_out,
    output alu_op_t alu_op_out,
    output lsu_op_t lsu_op_out,
    output logic [`XLEN-1:0] rdata1_out, rdata2_out,
    output logic [`REG_ADDR_W-1:0] waddr_out,
    output logic wren_out, jump,
    output logic [`XLEN-1:0] address,
    output logic mem_valid,
    output logic [3:0] mem_wstrb,
    output logic [`XLEN-1:0] mem_wdata,
    output logic exception,
    output ecause_t ecause,
    output logic [`XLEN-1:0] etval
);
    logic [`XLEN-1:0] imm, rdata1, rdata2, data1, data2, ag_address;
    logic [`REG_ADDR_W-1:0] waddr, raddr1, raddr2;
    logic wren, rden1, rden2, lui, auipc, jal, jalr, branch;
    logic load, store, ecall, ebreak, valid, taken, ag_exception;
    alu_op_t alu_op;
    bcu_op_t bcu_op;
    lsu_op_t lsu_op;
    logic [3:0] byteenable;
    ecause_t ag_ecause, ecause_d;
    logic wren_d, jump_d, load_d, store_d, exception_d;
    logic [`XLEN-1:0] etval_d, opa_d, wdata_d;

    instr_decoder i_instr_decoder (.*);
    register_file i_register_file (.*);
    operand_forward i_operand_forward (.*);
    branch_compare i_branch_compare (.*);

    address_gen i_address_gen (
        .pc, .data1, .imm, .jal, .jalr, .branch, .load, .store, .lsu_op,
        .address(ag_address), .byteenable, .exception(ag_exception), .ecause(ag_ecause)
    );

    assign stall = ex_busy && !clear;  // clear wins over a busy execute.

    always_comb begin
        jump_d = jal || jalr || taken;
        {wren_d, load_d, store_d} = {wren, load, store};
        exception_d = ag_exception;
        ecause_d = ag_ecause;
        etval_d = ag_exception ? ag_address : instr;
        // a misaligned access or target cancels the instruction
        if (ag_exception) begin
            if (load) begin
                {load_d, wren_d} = 2'b00;
            end else if (store) begin
                store_d = 1'b0;
            end else if (jump_d) begin
                {jump_d, wren_d} = 2'b00;
            end else begin
                exception_d = 1'b0;  // branch not taken.
            end
        end
        if (!valid) begin
            exception_d = 1'b1;
            ecause_d = except_illegal_instruction;
            etval_d = instr;
        end else if (ebreak) begin
            exception_d = 1'b1;
            ecause_d = except_breakpoint;
            etval_d = instr;
        end else if (ecall) begin
            exception_d = 1'b1;
            ecause_d = except_env_call_mach;
            etval_d = instr;
        end
        if (ex_busy || clear) begin
            {wren_d, jump_d, load_d, store_d, exception_d} = '0;
        end
        // execute takes operand a from here, pc for auipc.
        opa_d = auipc ? pc : (lui ? '0 : data1);
        case (lsu_op)
            lsu_sb: wdata_d = {4{data2[7:0]}};
            lsu_sh: wdata_d = {2{data2[15:0]}};
            default: wdata_d = data2;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            pc_out <= '0;
            imm_out <= '0;
            alu_op_out <= alu_add;
            lsu_op_out <= lsu_none;
            waddr_out <= '0;
            wren_out <= 1'b0;
            jump <= 1'b0;
            mem_valid <= 1'b0;
            mem_wstrb <= 4'b0000;
            exception <= 1'b0;
            ecause <= except_instr_misaligned;
            etval <= `NOP_INSTR;
        end else begin
            pc_out <= pc;
            imm_out <= imm;
            alu_op_out <= alu_op;
            lsu_op_out <= lsu_op;
            waddr_out <= waddr;
            wren_out <= wren_d;
            jump <= jump_d;
            mem_valid <= load_d || store_d;
            mem_wstrb <= store_d ? byteenable : 4'b0000;
            exception <= exception_d;
            ecause <= ecause_d;
            etval <= etval_d;
        end
    end

    always_ff @(posedge clock) begin
        npc <= pc + `XLEN'd4;
        rdata1_out <= opa_d;
        rdata2_out <= data2;
        address <= ag_address;
        mem_wdata <= wdata_d;
    end

endmodule

/* hdl/decode_top.sv */
`include "decode_macros.svh"

module decode_top
    import decode_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] instr,
    input  logic ex_busy,
    input  logic clear,
    input  logic ex_wren,
    input  logic [`REG_ADDR_W-1:0] ex_waddr,
    input  logic [`XLEN-1:0] ex_wdata,
    input  logic wb_wren,
    input  logic [`REG_ADDR_W-1:0] wb_waddr,
    input  logic [`XLEN-1:0] wb_wdata,
    output logic stall,  // combinational, fetch holds while high.
    output logic [`XLEN-1:0] pc_out,
    output logic [`XLEN-1:0] npc,
    output logic [`XLEN-1:0] imm_out,
    output alu_op_t alu_op_out,
    output lsu_op_t lsu_op_out,
    output logic [`XLEN-1:0] rdata1_out,
    output logic [`XLEN-1:0] rdata2_out,
    output logic [`REG_ADDR_W-1:0] waddr_out,
    output logic wren_out,
    output logic jump,
    output logic [`XLEN-1:0] address,
    output logic mem_valid,
    output logic [3:0] mem_wstrb,
    output logic [`XLEN-1:0] mem_wdata,
    output logic exception,
    output ecause_t ecause,
    output logic [`XLEN-1:0] etval
);

    // everything but stall is registered inside the stage.
    decode_stage i_decode_stage (.*);

endmodule

/* tests/decode_tb.sv */
`include "decode_macros.svh"

module decode_tb
    import decode_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
        logic [4:0] flags;  // ex_busy, clear, ex_wren, wb_wren, check imm.
        logic [`REG_ADDR_W-1:0] ex_waddr;
        logic [`XLEN-1:0] ex_wdata;
        logic [`REG_ADDR_W-1:0] wb_waddr;
        logic [`XLEN-1:0] wb_wdata;
        logic [`XLEN-1:0] imm;
        alu_op_t alu;
        logic [2:0] ctl;  // jump, mem_valid, exception.
        logic [`XLEN-1:0] address;
        logic [3:0] wstrb;
        ecause_t cause;
        logic [`XLEN-1:0] rdata1;
        lsu_op_t lsu;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0] rdata2;
        logic [`XLEN-1:0] wdata;
    } step_t;

    localparam int num_steps = 24;
    localparam int reset_limit = 20;
    localparam ecause_t no_cause = except_instr_misaligned;

    logic clock, reset;
    logic [`XLEN-1:0] pc, instr;
    logic ex_busy, clear, ex_wren, wb_wren;
    logic [`REG_ADDR_W-1:0] ex_waddr, wb_waddr;
    logic [`XLEN-1:0] ex_wdata, wb_wdata;
    logic stall, wren_out, jump, mem_valid, exception;
    logic [`XLEN-1:0] pc_out, npc, imm_out, rdata1_out, rdata2_out;
    logic [`XLEN-1:0] address, mem_wdata, etval;
    alu_op_t alu_op_out;
    lsu_op_t lsu_op_out;
    logic [`REG_ADDR_W-1:0] waddr_out;
    logic [3:0] mem_wstrb;
    ecause_t ecause;

    step_t steps [num_steps];
    int step_idx;

    decode_top i_decode_top (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (4) @(posedge clock);
        #1 reset = 1'b1;
    end

    initial begin
        #5000;
        abort_run("timeout: the run did not finish within 5000 ns");
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_alu(input alu_op_t got, input alu_op_t want, input string what);
        if (got !== want) begin
            abort_run($sformatf("FAIL at %0t: step %0d %s is %s, expected %s", $time,
                                step_idx, what, got.name(), want.name()));
        end
    endtask

    task automatic check_lsu(input lsu_op_t got, input lsu_op_t want, input string what);
        if (got !== want) begin
            abort_run($sformatf("FAIL at %0t: step %0d %s is %s, expected %s", $time,
                                step_idx, what, got.name(), want.name()));
        end
    endtask

    task automatic check_cause(input ecause_t got, input ecause_t want, input string what);
        if (got !== want) begin
            abort_run($sformatf("FAIL at %0t: step %0d %s is %s, expected %s", $time,
                                step_idx, what, got.name(), want.name()));
        end
    endtask

    task automatic check_word(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] want,
                              input string what);
        if (got !== want) begin
            abort_run($sformatf("FAIL at %0t: step %0d %s is %h, expected %h", $time,
                                step_idx, what, got, want));
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            abort_run($sformatf("FAIL at %0t: step %0d %s is %b, expected %b", $time,
                                step_idx, what, got, want));
        end
    endtask

    // pc, instr, flags, ex port, wb port, then imm, alu, ctl, address, wstrb, cause, rdata1,
    // then lsu, waddr, rdata2, wdata.
    task automatic fill_table();
        steps[0] = '{'h100, 'h00500093, 5'b00001, '0, '0, '0, '0, 'd5,
                     alu_add, 3'b000, '0, '0, no_cause, '0,
                     lsu_none, 5'd1, '0, '0};  // addi x1, x0, 5.
        steps[1] = '{'h104, 'h002081b3, 5'b00000, '0, '0, '0, '0, '0,
                     alu_add, 3'b000, '0, '0, no_cause, '0,
                     lsu_none, 5'd3, '0, '0};
        steps[2] = '{'h108, 'h40208233, 5'b00000, '0, '0, '0, '0, '0,
                     alu_sub, 3'b000, '0, '0, no_cause, '0,
                     lsu_none, 5'd4, '0, '0};
        steps[3] = '{'h10c, 'h123453b7, 5'b00001, '0, '0, '0, '0, 'h12345000,
                     alu_pass_b, 3'b000, '0, '0, no_cause, '0,
                     lsu_none, 5'd7, '0, '0};
        steps[4] = '{'h110, 'h4020d433, 5'b00000, '0, '0, '0, '0, '0,
                     alu_sra, 3'b000, '0, '0, no_cause, '0,
                     lsu_none, 5'd8, '0, '0};
        // writeback fills x5, read back through the register file next step.
        steps[5] = '{'h114, `NOP_INSTR, 5'b00011, '0, '0, 5'd5, 'hcafe0005, '0,
                     alu_add, 3'b000, '0, '0, no_cause, '0,
                     lsu_none, 5'd0, '0, '0};
        steps[6] = '{'h118, 'h00128493, 5'b00001, '0, '0, '0, '0, 'd1,
                     alu_add, 3'b000, '0, '0, no_cause, 'hcafe0005,
                     lsu_none, 5'd9, '0, '0};
        steps[7] = '{'h11c, 'h00030513, 5'b00111, 5'd6, 'h11111111, 5'd6, 'h22222222, '0,
                     alu_add, 3'b000, '0, '0, no_cause, 'h11111111,
                     lsu_none, 5'd10, '0, '0};
        steps[8] = '{'h120, 'h00000593, 5'b00111, 5'd0, 'hdead0000, 5'd0, 'hbeef0000, '0,
                     alu_add, 3'b000, '0, '0, no_cause, '0,
                     lsu_none, 5'd11, '0, '0};
        steps[9] = '{'h200, 'h00528863, 5'b00001, '0, '0, '0, '0, 'd16,
                     alu_add, 3'b100, 'h210, '0, no_cause, 'hcafe0005,
                     lsu_none, 5'd16, 'hcafe0005, 'hcafe0005};
        steps[10] = '{'h204, 'h00628863, 5'b00100, 5'd6, 'hcafe0005, '0, '0, '0,
                      alu_add, 3'b100, 'h214, '0, no_cause, 'hcafe0005,
                      lsu_none, 5'd16, 'hcafe0005, 'hcafe0005};
        steps[11] = '{'h208, 'h00628863, 5'b00000, '0, '0, '0, '0, '0,
                      alu_add, 3'b000, 'h218, '0, no_cause, 'hcafe0005,
                      lsu_none, 5'd16, 'h22222222, 'h22222222};
        steps[12] = '{'h20c, 'h00536863, 5'b00000, '0, '0, '0, '0, '0,
                      alu_add, 3'b100, 'h21c, '0, no_cause, 'h22222222,
                      lsu_none, 5'd16, 'hcafe0005, 'hcafe0005};  // bltu x6, x5.
        steps[13] = '{'h210, 'h0062e863, 5'b00000, '0, '0, '0, '0, '0,
                      alu_add, 3'b000, 'h220, '0, no_cause, 'hcafe0005,
                      lsu_none, 5'd16, 'h22222222, 'h22222222};
        steps[14] = '{'h300, 'h040000ef, 5'b00001, '0, '0, '0, '0, 'h40,
                      alu_add, 3'b100, 'h340, '0, no_cause, '0,
                      lsu_none, 5'd1, '0, '0};  // jal x1, 0x40.
        steps[15] = '{'h304, 'h0046a603, 5'b00101, 5'd13, 'h1000, '0, '0, 'd4,
                      alu_add, 3'b010, 'h1004, 4'b0000, no_cause, 'h1000,
                      lsu_lw, 5'd12, '0, '0};
        // store data comes from writeback, its low halfword lands in both halves.
        steps[16] = '{'h308, 'h00669323, 5'b00111, 5'd13, 'h1000, 5'd6, 'h5555abcd, 'd6,
                      alu_add, 3'b010, 'h1006, 4'b1100, no_cause, 'h1000,
                      lsu_sh, 5'd6, 'h5555abcd, 'habcdabcd};
        steps[17] = '{'h30c, 'h00202603, 5'b00001, '0, '0, '0, '0, 'd2,
                      alu_add, 3'b001, 'd2, '0, except_load_misaligned, '0,
                      lsu_lw, 5'd12, '0, '0};
        steps[18] = '{'h310, 'h00000000, 5'b00001, '0, '0, '0, '0, '0,
                      alu_add, 3'b001, '0, '0, except_illegal_instruction, '0,
                      lsu_none, 5'd0, '0, '0};
        steps[19] = '{'h314, 'h00100073, 5'b00000, '0, '0, '0, '0, '0,
                      alu_add, 3'b001, '0, '0, except_breakpoint, '0,
                      lsu_none, 5'd0, '0, '0};
        steps[20] = '{'h318, 'h00000073, 5'b00000, '0, '0, '0, '0, '0,
                      alu_add, 3'b001, '0, '0, except_env_call_mach, '0,
                      lsu_none, 5'd0, '0, '0};
        // bubbles from a busy execute, then clear on top of it.
        steps[21] = '{'h300, 'h040000ef, 5'b10000, '0, '0, '0, '0, '0,
                      alu_add, 3'b000, 'h340, '0, no_cause, '0,
                      lsu_none, 5'd1, '0, '0};
        steps[22] = '{'h318, 'h00000073, 5'b10000, '0, '0, '0, '0, '0,
                      alu_add, 3'b000, '0, '0, no_cause, '0,
                      lsu_none, 5'd0, '0, '0};
        steps[23] = '{'h30c, 'h00202603, 5'b11000, '0, '0, '0, '0, '0,
                      alu_add, 3'b000, 'd2, '0, no_cause, '0,
                      lsu_lw, 5'd12, '0, '0};
    endtask

    initial begin
        int waited;
        step_t s;
        pc = '0;
        instr = `NOP_INSTR;
        {ex_busy, clear, ex_wren, wb_wren} = 4'b0000;
        ex_waddr = '0;
        ex_wdata = '0;
        wb_waddr = '0;
        wb_wdata = '0;
        step_idx = -1;
        fill_table();
        waited = 0;
        while (reset !== 1'b1) begin
            @(negedge clock);
            waited++;
            if (waited > reset_limit) begin
                abort_run("timeout: reset was never released");
            end
        end
        // output register still holds the nop loaded during reset.
        check_bit(stall, 1'b0, "stall after reset");
        check_bit(jump, 1'b0, "jump after reset");
        check_bit(mem_valid, 1'b0, "mem_valid after reset");
        check_bit(exception, 1'b0, "exception after reset");
        check_bit(wren_out, 1'b0, "wren after reset");
        check_word(pc_out, '0, "pc_out after reset");
        check_alu(alu_op_out, alu_add, "alu_op after reset");
        @(posedge clock);
        #1;
        for (step_idx = 0; step_idx < num_steps; step_idx++) begin
            s = steps[step_idx];
            pc = s.pc;
            instr = s.instr;
            {ex_busy, clear, ex_wren, wb_wren} = s.flags[4:1];
            {ex_waddr, ex_wdata, wb_waddr, wb_wdata} = {s.ex_waddr, s.ex_wdata,
                                                        s.wb_waddr, s.wb_wdata};
            #1;
            check_bit(stall, s.flags[4] && !s.flags[3], "stall");  // same cycle.
            @(posedge clock);
            #1;
            check_word(pc_out, s.pc, "pc_out");
            check_word(npc, s.pc + 32'd4, "npc");
            if (s.flags[0]) begin
                check_word(imm_out, s.imm, "imm");
            end
            check_alu(alu_op_out, s.alu, "alu_op");
            check_lsu(lsu_op_out, s.lsu, "lsu_op");
            check_word({27'd0, waddr_out}, {27'd0, s.waddr}, "waddr");
            check_bit(jump, s.ctl[2], "jump");
            check_word(address, s.address, "address");
            check_bit(mem_valid, s.ctl[1], "mem_valid");
            check_word({28'd0, mem_wstrb}, {28'd0, s.wstrb}, "mem_wstrb");
            check_word(mem_wdata, s.wdata, "mem_wdata");
            check_bit(exception, s.ctl[0], "exception");
            check_word(rdata1_out, s.rdata1, "rdata1");
            check_word(rdata2_out, s.rdata2, "rdata2");
            if (s.ctl[0] || s.flags[4] || s.flags[3]) begin
                check_bit(wren_out, 1'b0, "wren");
            end
            if (s.ctl[0]) begin
                check_cause(ecause, s.cause, "ecause");
                if (s.cause inside {except_illegal_instruction, except_breakpoint,
                                    except_env_call_mach}) begin
                    check_word(etval, s.instr, "etval");
                end
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
hdl/decode_pkg.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/operand_forward.sv
hdl/branch_compare.sv
hdl/address_gen.sv
hdl/decode_stage.sv
hdl/decode_top.sv
tests/decode_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module decode_tb \
    -f flist.f -o decode_sim &&
./obj_dir/decode_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
